// ==== sources.f ====
+incdir+logic
+incdir+verification
logic/xgmii_tx_pkg.sv
logic/tx_crc32.sv
logic/tx_fcs_lane_map.sv
logic/tx_frame_fsm.sv
logic/xgmii_tx_top.sv
verification/tb_xgmii_tx.sv

// ==== Makefile ====
SRCS := $(wildcard logic/*.sv logic/*.svh verification/*.sv verification/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_xgmii_tx
	./obj_dir/Vtb_xgmii_tx | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

obj_dir/Vtb_xgmii_tx: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_xgmii_tx -o Vtb_xgmii_tx

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_frame_table.svh ====
// test frame rows for the xgmii transmitter testbench, included inside the testbench module
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

localparam int num_rows = 20;

// columns: length, bad flag, underflow beat (0 none), cfg_ifg, gap check, error expected
localparam int frame_table [num_rows][6] = '{
    '{ 60, 0, 0, 12, 0, 0},
    '{ 61, 0, 0, 12, 1, 0},
    '{ 62, 0, 0, 12, 1, 0},
    '{ 63, 0, 0, 12, 1, 0},
    '{ 64, 0, 0, 12, 1, 0},
    '{ 65, 0, 0, 12, 1, 0},
    '{ 66, 0, 0, 12, 1, 0},
    '{ 67, 0, 0, 12, 1, 0},
    '{100, 0, 0, 12, 1, 0},
    // short frames get zero padding
    '{ 20, 0, 0, 12, 1, 0},
    '{  1, 0, 0, 12, 1, 0},
    '{ 70, 1, 0, 12, 1, 1},
    '{ 80, 0, 3, 12, 1, 1},
    // gap after the drained frame is not bounded
    '{ 72, 0, 0,  8, 0, 0},
    '{ 61, 0, 0,  8, 1, 0},
    '{ 93, 0, 0,  8, 1, 0},
    '{ 64, 0, 0, 20, 0, 0},
    '{ 75, 0, 0, 20, 1, 0},
    '{ 59, 0, 0, 20, 1, 0},
    '{ 62, 0, 0, 20, 1, 0}
};

`endif

// ==== verification/tb_xgmii_tx.sv ====
// testbench for the xgmii transmitter, runs the frame table and prints a result per frame
`timescale 1ns/100ps
`default_nettype none

`include "xgmii_tx_macros.svh"

module tb_xgmii_tx import xgmii_tx_pkg::*; ();

    `include "tb_frame_table.svh"

    logic clk, reset_crc, s_tvalid, s_tlast, s_tuser, s_tready, cfg_tx_enable, error_underflow;
    xgmii_data_t s_tdata, xgmii_txd;
    xgmii_ctrl_t s_tkeep, xgmii_txc;
    ifg_count_t  cfg_ifg;

    logic [31:0] lfsr = 32'hc970_29fc;
    logic [31:0] exp_fcs;
    logic [7:0]  payload[$];
    logic [7:0]  expected[$];
    logic [7:0]  cur[$];
    logic [7:0]  got_bytes[$];
    logic [7:0]  lane;
    logic        in_pkt = 0, cur_err = 0, got_err = 0, seen_term = 0, got_gap_valid = 0;
    int          gap_count = 0, last_gap = 0, got_gap = 0, frames_done = 0, uf_pulses = 0;
    int          errors = 0, failed_tests = 0, start_errs, start_uf, gap_min, r;
    logic        timed_out = 0;

    xgmii_tx_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // reflected crc-32 taken lsb first and inverted at the end
    function automatic logic [31:0] eth_crc(input logic [7:0] bytes[$]);
        logic [31:0] c;
        c = '1;
        foreach (bytes[i]) begin
            for (int k = 0; k < 8; k++) begin
                c = (c[0] ^ bytes[i][k]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!s_tready && !timed_out) begin
            @(negedge clk);
            cnt++;
            if (cnt > 300) begin
                $display("timeout: s_tready never came back at %0t", $time);
                timed_out = 1;
            end
        end
    endtask

    task automatic wait_frame(input int target);
        int cnt;
        cnt = 0;
        while (frames_done < target && !timed_out) begin
            @(negedge clk);
            cnt++;
            if (cnt > 300) begin
                $display("timeout: no terminate character seen at %0t", $time);
                timed_out = 1;
            end
        end
    endtask

    task automatic send_frame(input int len, input int bad, input int uf_beat);
        int nbeats;
        nbeats = (len + 7) / 8;
        for (int b = 0; b < nbeats && !timed_out; b++) begin
            if (uf_beat != 0 && b == uf_beat) begin
                s_tvalid = 1'b0;
                @(negedge clk);
            end
            s_tdata = '0;
            s_tkeep = '0;
            for (int i = 0; i < 8; i++) begin
                if (b*8 + i < len) begin
                    s_tdata[i*8 +: 8] = payload[b*8 + i];
                    s_tkeep[i] = 1'b1;
                end
            end
            s_tvalid = 1'b1;
            s_tlast = (b == nbeats - 1);
            s_tuser = bad != 0 && s_tlast;
            wait_ready();
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    // xgmii monitor sampled on the falling edge
    always @(negedge clk) begin
        if (error_underflow) uf_pulses++;
        for (int i = 0; i < 8; i++) begin
            lane = xgmii_txd[i*8 +: 8];
            if (!xgmii_txc[i]) begin
                if (in_pkt) cur.push_back(lane);
            end else if (lane == `XGMII_START) begin
                in_pkt = 1;
                cur.delete();
                cur_err = 0;
                last_gap = gap_count;
                got_gap_valid = seen_term;
            end else if (lane == `XGMII_TERM && in_pkt) begin
                in_pkt = 0;
                got_bytes = cur;
                got_err = cur_err;
                got_gap = last_gap;
                seen_term = 1;
                gap_count = 0;
                frames_done++;
            end else if (lane == `XGMII_ERROR && in_pkt) begin
                cur_err = 1;
            end else if (lane == `XGMII_IDLE && !in_pkt) begin
                gap_count++;
            end
        end
    end

    initial begin
        reset_crc = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b0;
        repeat (5) @(negedge clk);
        reset_crc = 1'b0;
        check_value("xgmii_txc", xgmii_txc, 8'hff);
        check_value("xgmii_txd", xgmii_txd, {8{`XGMII_IDLE}});
        repeat (10) begin
            @(negedge clk);
            check_value("s_tready", s_tready, 1'b0);
        end
        cfg_tx_enable = 1'b1;

        for (r = 0; r < num_rows && !timed_out; r++) begin
            cfg_ifg = ifg_count_t'(frame_table[r][3]);
            payload.delete();
            for (int n = 0; n < frame_table[r][0]; n++) begin
                payload.push_back(8'h00);
                for (int k = 0; k < 8; k++) begin
                    lfsr = lfsr_next(lfsr);
                    payload[n][k] = lfsr[0];
                end
            end
            start_errs = errors;
            start_uf = uf_pulses;
            send_frame(frame_table[r][0], frame_table[r][1], frame_table[r][2]);
            wait_frame(r + 1);
            if (timed_out) break;
            check_value("error termination", got_err, frame_table[r][5]);
            check_value("underflow pulses", uf_pulses - start_uf, frame_table[r][2] != 0);
            if (frame_table[r][2] != 0) begin
                // nothing after the dropped valid may reach xgmii
                check_value("bytes before underflow",
                            got_bytes.size() <= 7 + 8*frame_table[r][2], 1'b1);
            end else if (frame_table[r][5] == 0) begin
                expected = payload;
                while (expected.size() < `ETH_MIN_FRAME_LEN - 4) expected.push_back(8'h00);
                exp_fcs = eth_crc(expected);
                for (int k = 0; k < 4; k++) expected.push_back(exp_fcs[8*k +: 8]);
                for (int k = 0; k < 7; k++) expected.push_front(k == 0 ? `ETH_SFD : `ETH_PRE);
                check_value("frame length", got_bytes.size(), expected.size());
                for (int k = 0; k < expected.size() && errors == start_errs; k++) begin
                    check_value($sformatf("frame byte %0d", k), got_bytes[k], expected[k]);
                end
            end
            if (frame_table[r][4] != 0 && got_gap_valid) begin
                gap_min = (frame_table[r][3] > `ETH_MIN_IFG) ? frame_table[r][3] : `ETH_MIN_IFG;
                check_value("gap idle bytes in range",
                            got_gap >= gap_min && got_gap < gap_min + 8, 1'b1);
            end
            if (errors != start_errs) failed_tests++;
            $display("test %0d: length %0d gap %0d %s", r, frame_table[r][0], got_gap,
                     (errors == start_errs) ? "ok" : "failed");
        end

        $display("tests run %0d, failed %0d, errors %0d", r, failed_tests, errors);
        if (timed_out || errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/xgmii_tx_top.sv ====
// 64-bit ethernet transmitter from a valid/ready byte stream to xgmii, the design top level
`timescale 1ns/100ps
`default_nettype none

module xgmii_tx_top import xgmii_tx_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_crc,
    input  wire xgmii_data_t s_tdata,
    input  wire xgmii_ctrl_t s_tkeep,
    input  wire logic        s_tvalid,
    input  wire logic        s_tlast,
    input  wire logic        s_tuser,
    output wire logic        s_tready,
    input  wire ifg_count_t  cfg_ifg,
    input  wire logic        cfg_tx_enable,
    output wire xgmii_data_t xgmii_txd,
    output wire xgmii_ctrl_t xgmii_txc,
    output wire logic        error_underflow
);

    xgmii_data_t hold_data;
    lane_empty_t hold_empty;
    logic        crc_init;
    logic        crc_update;
    crc_t [7:0]  crc_next_by_width;
    crc_t [7:0]  crc_held_by_width;
    xgmii_data_t fcs_txd_0;
    xgmii_data_t fcs_txd_1;
    xgmii_ctrl_t fcs_txc_0;
    xgmii_ctrl_t fcs_txc_1;
    ifg_count_t  ifg_offset;

    tx_frame_fsm u_fsm (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .s_tdata         (s_tdata),
        .s_tkeep         (s_tkeep),
        .s_tvalid        (s_tvalid),
        .s_tlast         (s_tlast),
        .s_tuser         (s_tuser),
        .s_tready        (s_tready),
        .cfg_ifg         (cfg_ifg),
        .cfg_tx_enable   (cfg_tx_enable),
        .fcs_txd_0       (fcs_txd_0),
        .fcs_txd_1       (fcs_txd_1),
        .fcs_txc_0       (fcs_txc_0),
        .fcs_txc_1       (fcs_txc_1),
        .ifg_offset      (ifg_offset),
        .hold_data       (hold_data),
        .hold_empty      (hold_empty),
        .crc_init        (crc_init),
        .crc_update      (crc_update),
        .xgmii_txd       (xgmii_txd),
        .xgmii_txc       (xgmii_txc),
        .error_underflow (error_underflow)
    );

    tx_crc32 u_crc (
        .clk               (clk),
        .crc_init          (crc_init),
        .crc_update        (crc_update),
        .hold_data         (hold_data),
        .crc_next_by_width (crc_next_by_width),
        .crc_held_by_width (crc_held_by_width)
    );

    tx_fcs_lane_map u_lane_map (
        .hold_data         (hold_data),
        .hold_empty        (hold_empty),
        .crc_next_by_width (crc_next_by_width),
        .crc_held_by_width (crc_held_by_width),
        .fcs_txd_0         (fcs_txd_0),
        .fcs_txd_1         (fcs_txd_1),
        .fcs_txc_0         (fcs_txc_0),
        .fcs_txc_1         (fcs_txc_1),
        .ifg_offset        (ifg_offset)
    );

endmodule

`default_nettype wire

// ==== logic/tx_frame_fsm.sv ====
// frame sequencing from stream beats to xgmii words with padding, termination and gap, used by the top
`timescale 1ns/100ps
`default_nettype none

`include "xgmii_tx_macros.svh"

module tx_frame_fsm import xgmii_tx_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_crc,
    input  wire xgmii_data_t s_tdata,
    input  wire xgmii_ctrl_t s_tkeep,
    input  wire logic        s_tvalid,
    input  wire logic        s_tlast,
    input  wire logic        s_tuser,
    output logic             s_tready,
    input  wire ifg_count_t  cfg_ifg,
    input  wire logic        cfg_tx_enable,
    input  wire xgmii_data_t fcs_txd_0,
    input  wire xgmii_data_t fcs_txd_1,
    input  wire xgmii_ctrl_t fcs_txc_0,
    input  wire xgmii_ctrl_t fcs_txc_1,
    input  wire ifg_count_t  ifg_offset,
    output xgmii_data_t      hold_data,
    output lane_empty_t      hold_empty,
    output logic             crc_init,
    output logic             crc_update,
    output xgmii_data_t      xgmii_txd,
    output xgmii_ctrl_t      xgmii_txc,
    output logic             error_underflow
);

    // bytes still needed after the first beat, fcs excluded
    localparam logic [7:0] pad_start = 8'(`ETH_MIN_FRAME_LEN - 4 - `XGMII_CTRL_W);

    function automatic lane_empty_t keep_to_empty(input xgmii_ctrl_t keep);
        lane_empty_t empty;
        empty = 3'd7;
        for (int i = 1; i < `XGMII_CTRL_W; i++) begin
            if (keep[i]) begin
                empty = lane_empty_t'(7 - i);
            end
        end
        return empty;
    endfunction

    tx_state_t   state;
    tx_state_t   state_next;
    logic        in_frame;
    logic        in_frame_next;
    logic [7:0]  pad_count;
    logic [7:0]  pad_count_next;
    ifg_count_t  ifg_count;
    ifg_count_t  ifg_count_next;
    ifg_count_t  gap_target;
    logic        tready_next;
    logic        underflow_next;
    logic        beat;
    xgmii_data_t tdata_masked;
    xgmii_data_t hold_data_next;
    lane_empty_t hold_empty_next;
    xgmii_data_t txd_next;
    xgmii_ctrl_t txc_next;

    assign beat = s_tvalid && s_tready;
    assign gap_target = (cfg_ifg > ifg_count_t'(`ETH_MIN_IFG)) ? cfg_ifg
                                                                : ifg_count_t'(`ETH_MIN_IFG);

    // zero the bytes outside tkeep
    always_comb begin
        for (int i = 0; i < `XGMII_CTRL_W; i++) begin
            tdata_masked[i*8 +: 8] = s_tkeep[i] ? s_tdata[i*8 +: 8] : 8'h00;
        end
    end

    always_comb begin
        state_next = state;
        in_frame_next = in_frame;
        pad_count_next = pad_count;
        ifg_count_next = ifg_count;
        tready_next = 1'b0;
        underflow_next = 1'b0;
        hold_data_next = hold_data;
        hold_empty_next = hold_empty;
        txd_next = {`XGMII_CTRL_W{`XGMII_IDLE}};
        txc_next = '1;
        crc_init = 1'b0;
        crc_update = 1'b0;

        if (beat) begin
            in_frame_next = !s_tlast;
        end

        case (state)
            state_idle: begin
                crc_init = 1'b1;
                pad_count_next = pad_start;
                tready_next = cfg_tx_enable;
                hold_data_next = tdata_masked;
                hold_empty_next = keep_to_empty(s_tkeep);
                if (beat) begin
                    txd_next = {`ETH_SFD, {6{`ETH_PRE}}, `XGMII_START};
                    txc_next = 8'h01;
                    tready_next = !s_tlast;
                    if (!s_tlast) begin
                        state_next = state_payload;
                    end else if (s_tuser) begin
                        state_next = state_err;
                    end else begin
                        // single-beat frame, padding always follows
                        hold_empty_next = '0;
                        state_next = state_pad;
                    end
                end
            end
            state_payload: begin
                crc_update = 1'b1;
                tready_next = 1'b1;
                txd_next = hold_data;
                txc_next = '0;
                hold_data_next = tdata_masked;
                hold_empty_next = keep_to_empty(s_tkeep);
                pad_count_next = (pad_count > 8'd8) ? pad_count - 8'd8 : 8'd0;
                if (!s_tvalid || s_tlast) begin
                    // keep ready up to drain a broken frame
                    tready_next = in_frame_next;
                    underflow_next = !s_tvalid;
                    if (!s_tvalid || s_tuser) begin
                        state_next = state_err;
                    end else if (pad_count > 8'd8) begin
                        hold_empty_next = '0;
                        state_next = state_pad;
                    end else begin
                        if (pad_count != 0 && hold_empty_next > lane_empty_t'(8 - pad_count)) begin
                            hold_empty_next = lane_empty_t'(8 - pad_count);
                        end
                        state_next = state_fcs_1;
                    end
                end
            end
            state_pad: begin
                crc_update = 1'b1;
                txd_next = hold_data;
                txc_next = '0;
                hold_data_next = '0;
                hold_empty_next = '0;
                if (pad_count > 8'd8) begin
                    pad_count_next = pad_count - 8'd8;
                end else begin
                    pad_count_next = '0;
                    hold_empty_next = lane_empty_t'(8 - pad_count);
                    state_next = state_fcs_1;
                end
            end
            state_fcs_1: begin
                txd_next = fcs_txd_0;
                txc_next = fcs_txc_0;
                ifg_count_next = gap_target - ifg_offset;
                // four or more data bytes push the terminate into the next word
                state_next = (hold_empty <= 3'd4) ? state_fcs_2 : state_ifg;
            end
            state_fcs_2: begin
                txd_next = fcs_txd_1;
                txc_next = fcs_txc_1;
                state_next = state_ifg;
            end
            state_err: begin
                tready_next = in_frame_next;
                txd_next = {`XGMII_TERM, {7{`XGMII_ERROR}}};
                txc_next = '1;
                ifg_count_next = gap_target;
                state_next = state_ifg;
            end
            state_ifg: begin
                tready_next = in_frame_next;
                ifg_count_next = (ifg_count > 8'd8) ? ifg_count - 8'd8 : 8'd0;
                if (ifg_count_next == 0 && !in_frame_next) begin
                    tready_next = cfg_tx_enable;
                    state_next = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= state_idle;
            in_frame <= 1'b0;
            ifg_count <= '0;
            s_tready <= 1'b0;
            error_underflow <= 1'b0;
            xgmii_txd <= {`XGMII_CTRL_W{`XGMII_IDLE}};
            xgmii_txc <= '1;
        end else begin
            state <= state_next;
            in_frame <= in_frame_next;
            ifg_count <= ifg_count_next;
            s_tready <= tready_next;
            error_underflow <= underflow_next;
            xgmii_txd <= txd_next;
            xgmii_txc <= txc_next;
        end
    end

    always_ff @(posedge clk) begin
        hold_data <= hold_data_next;
        hold_empty <= hold_empty_next;
        pad_count <= pad_count_next;
    end

    // keep runs from lane 0 and only the last beat may be partial
    keep_contiguous: assert property (@(posedge clk) disable iff (reset_crc)
        beat |-> s_tkeep != '0 && (s_tkeep & (s_tkeep + 1'b1)) == '0
                 && (s_tlast || &s_tkeep))
        else $error("illegal s_tkeep %h", s_tkeep);

endmodule

`default_nettype wire

// ==== logic/tx_fcs_lane_map.sv ====
// places fcs, terminate and idle bytes after the last data byte of a frame, used by the top level
`timescale 1ns/100ps
`default_nettype none

`include "xgmii_tx_macros.svh"

module tx_fcs_lane_map import xgmii_tx_pkg::*; (
    input  wire xgmii_data_t hold_data,
    input  wire lane_empty_t hold_empty,
    input  wire crc_t [7:0]  crc_next_by_width,
    input  wire crc_t [7:0]  crc_held_by_width,
    output xgmii_data_t      fcs_txd_0,
    output xgmii_data_t      fcs_txd_1,
    output xgmii_ctrl_t      fcs_txc_0,
    output xgmii_ctrl_t      fcs_txc_1,
    output ifg_count_t       ifg_offset
);

    always_comb begin
        int used;
        int term_lane;
        crc_t fcs_0;
        crc_t fcs_1;
        logic [1:0] fcs_byte;
        logic [2*`XGMII_DATA_W-1:0] txd_pair;
        logic [2*`XGMII_CTRL_W-1:0] txc_pair;

        // data bytes left in the final beat
        used = `XGMII_CTRL_W - int'(hold_empty);
        term_lane = used + 4;

        // second word is sent a cycle later, so it reads the registered copy
        fcs_0 = ~crc_next_by_width[used-1];
        fcs_1 = ~crc_held_by_width[used-1];

        // lanes 0..7 form the first word, 8..15 the second
        for (int i = 0; i < 2*`XGMII_CTRL_W; i++) begin
            fcs_byte = 2'(i - used);
            txc_pair[i] = (i >= term_lane);
            if (i < used) begin
                txd_pair[i*8 +: 8] = hold_data[(i % 8)*8 +: 8];
            end else if (i < term_lane) begin
                if (i < `XGMII_CTRL_W) begin
                    txd_pair[i*8 +: 8] = fcs_0[fcs_byte*8 +: 8];
                end else begin
                    txd_pair[i*8 +: 8] = fcs_1[fcs_byte*8 +: 8];
                end
            end else if (i == term_lane) begin
                txd_pair[i*8 +: 8] = `XGMII_TERM;
            end else begin
                txd_pair[i*8 +: 8] = `XGMII_IDLE;
            end
        end

        fcs_txd_0 = txd_pair[`XGMII_DATA_W-1:0];
        fcs_txd_1 = txd_pair[2*`XGMII_DATA_W-1:`XGMII_DATA_W];
        fcs_txc_0 = txc_pair[`XGMII_CTRL_W-1:0];
        fcs_txc_1 = txc_pair[2*`XGMII_CTRL_W-1:`XGMII_CTRL_W];

        // idle bytes behind the terminate character in its own word
        if (term_lane < `XGMII_CTRL_W) begin
            ifg_offset = ifg_count_t'(`XGMII_CTRL_W - 1 - term_lane);
        end else begin
            ifg_offset = ifg_count_t'(2*`XGMII_CTRL_W - 1 - term_lane);
        end
    end

endmodule

`default_nettype wire

// ==== logic/tx_crc32.sv ====
// parallel ethernet crc-32 over the held beat, one result per byte width, used by the top level
`timescale 1ns/100ps
`default_nettype none

`include "xgmii_tx_macros.svh"

module tx_crc32 import xgmii_tx_pkg::*; (
    input  wire logic        clk,
    input  wire logic        crc_init,
    input  wire logic        crc_update,
    input  wire xgmii_data_t hold_data,
    output crc_t [7:0]       crc_next_by_width,
    output crc_t [7:0]       crc_held_by_width
);

    function automatic crc_t reflect32(input crc_t value);
        crc_t result;
        for (int i = 0; i < 32; i++) begin
            result[i] = value[31-i];
        end
        return result;
    endfunction

    // lsb-first shift needs the bit-reversed polynomial
    localparam crc_t poly_refl = reflect32(`CRC_POLY);

    function automatic crc_t crc_byte(input crc_t state, input logic [7:0] data);
        crc_t c;
        c = state;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ poly_refl;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    crc_t crc_state;

    // entry n covers bytes 0..n of the held beat
    always_comb begin
        crc_t chain;
        chain = crc_state;
        for (int n = 0; n < 8; n++) begin
            chain = crc_byte(chain, hold_data[n*8 +: 8]);
            crc_next_by_width[n] = chain;
        end
    end

    always_ff @(posedge clk) begin
        if (crc_init) begin
            crc_state <= '1;
        end else if (crc_update) begin
            crc_state <= crc_next_by_width[7];
        end
        // kept for the fcs bytes that spill into the second word
        crc_held_by_width <= crc_next_by_width;
    end

    // fsm must never restart and advance the crc in one cycle
    init_update_excl: assert property (@(posedge clk) !(crc_init && crc_update))
        else $error("crc_init and crc_update both high");

endmodule

`default_nettype wire

// ==== logic/xgmii_tx_pkg.sv ====
// types for the xgmii frame transmitter, imported by the rtl modules and the testbench
`default_nettype none

`include "xgmii_tx_macros.svh"

package xgmii_tx_pkg;

    typedef logic [`XGMII_DATA_W-1:0] xgmii_data_t;
    typedef logic [`XGMII_CTRL_W-1:0] xgmii_ctrl_t;

    // unused bytes in the final beat of a frame
    typedef logic [2:0] lane_empty_t;

    typedef logic [31:0] crc_t;

    // gap length in bytes
    typedef logic [7:0] ifg_count_t;

    typedef enum logic [2:0] {
        state_idle,
        state_payload,
        state_pad,
        state_fcs_1,
        state_fcs_2,
        state_err,
        state_ifg
    } tx_state_t;

endpackage

`default_nettype wire

// ==== logic/xgmii_tx_macros.svh ====
// widths, xgmii control characters and frame limits shared by the transmitter rtl and testbench
`ifndef XGMII_TX_MACROS_SVH
`define XGMII_TX_MACROS_SVH

// xgmii word geometry
`define XGMII_DATA_W 64
`define XGMII_CTRL_W 8

// control characters
`define XGMII_IDLE  8'h07
`define XGMII_START 8'hfb
`define XGMII_TERM  8'hfd
`define XGMII_ERROR 8'hfe

// preamble and start frame delimiter
`define ETH_PRE 8'h55
`define ETH_SFD 8'hd5

// minimum frame length including the fcs, and minimum gap in bytes
`define ETH_MIN_FRAME_LEN 64
`define ETH_MIN_IFG 12

// normal form of the ethernet crc-32 polynomial
`define CRC_POLY 32'h04c1_1db7

`endif
